/* build.f */
rtl/hazard_pkg.sv
rtl/instr_decode.sv
rtl/reg_scoreboard.sv
rtl/wb_pipeline.sv
rtl/issue_hazard_top.sv
verification/tb_issue_hazard.sv

/* Makefile */
# Verilator build and run of the issue stage testbench

VERILATOR ?= verilator
TOP       ?= tb_issue_hazard
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_issue_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_issue_hazard
	import hazard_pkg::*;
();

	localparam int LAT_ALU      = 1;
	localparam int LAT_LOAD     = 3;
	localparam int TOTAL_ISSUES = 58;	// issues over all tests
	localparam int MAX_CYCLES   = TOTAL_ISSUES * (LAT_LOAD + 2) + 200;

	logic        clk;
	logic        nrst;
	logic [31:0] instr;
	logic        instr_valid;
	logic        btaken;
	logic        exception;
	logic        stall;
	logic        issue;
	logic        kill;
	logic        wb_valid;
	reg_idx_t    wb_rd;

	int     cnt [NUM_REGS];	// cycles left to write-back or 0 when not pending
	logic   prev_flush;
	int     wb_count;
	int     pass_count;
	int     fail_count;
	int     cycles;
	integer seed;

	issue_hazard_top #(
		.LAT_ALU  (LAT_ALU),
		.LAT_LOAD (LAT_LOAD)
	) DUT (
		.clk         (clk),
		.nrst        (nrst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.btaken      (btaken),
		.exception   (exception),
		.stall       (stall),
		.issue       (issue),
		.kill        (kill),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [31:0] make_instr(opcode_t op, reg_idx_t rd, reg_idx_t rs1,
		reg_idx_t rs2);
		return {7'b0, rs2, rs1, 3'b0, rd, op};
	endfunction

	function automatic fu_class_t class_of(opcode_t op);
		case (op)
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OP_IMM, OPC_OP: return FU_ALU;
			OPC_BRANCH: return FU_BRANCH;
			OPC_LOAD:   return FU_LOAD;
			OPC_STORE:  return FU_STORE;
			default:    return FU_NONE;
		endcase
	endfunction

	function automatic logic reads_rs1(opcode_t op);
		return op inside {OPC_JALR, OPC_OP_IMM, OPC_OP, OPC_BRANCH, OPC_LOAD, OPC_STORE};
	endfunction

	function automatic logic reads_rs2(opcode_t op);
		return op inside {OPC_OP, OPC_BRANCH, OPC_STORE};
	endfunction

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			fail_count++;
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
		end
		else
			pass_count++;
	endtask

	task automatic compare_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
		if (act !== exp)
		begin
			fail_count++;
			$display("[ERROR] %0t %s expected x%0d actual x%0d", $time, name, exp, act);
		end
		else
			pass_count++;
	endtask

	task automatic check_count(input string what, input int exp, input int got);
		if (got != exp)
		begin
			fail_count++;
			$display("%s was %0d but should be %0d", what, got, exp);
		end
		else
			pass_count++;
	endtask

	// drive on the rising edge and check the response at the falling edge
	task automatic step(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2, input logic valid, input logic bt, input logic ex,
		output logic issued);
		fu_class_t cls;
		logic      wr;
		logic      flush;
		logic      hazard;
		logic      slot_busy;
		logic      exp_issue;
		logic      exp_wb;
		reg_idx_t  exp_rd;
		@(posedge clk);
		instr       <= make_instr(op, rd, rs1, rs2);
		instr_valid <= valid;
		btaken      <= bt;
		exception   <= ex;
		@(negedge clk);
		cls       = class_of(op);
		wr        = ((cls == FU_ALU) || (cls == FU_LOAD)) && (rd != 0);
		flush     = bt || ex;
		slot_busy = 1'b0;
		exp_wb    = 1'b0;
		exp_rd    = '0;
		for (int r = 0; r < NUM_REGS; r++)
		begin
			if (cnt[r] == LAT_ALU + 1)
				slot_busy = 1'b1;	// older result lands in the alu slot
			if (cnt[r] == 1)
			begin
				exp_wb = 1'b1;
				exp_rd = reg_idx_t'(r);
			end
		end
		// pending with count 1 is written back now and counts as ready
		hazard = (reads_rs1(op) && cnt[rs1] > 1) || (reads_rs2(op) && cnt[rs2] > 1) ||
		         (wr && cnt[rd] > 1) || (cls == FU_ALU && wr && slot_busy);
		exp_issue = valid && !flush && !hazard;
		compare_bit("stall", valid && !flush && hazard, stall);
		compare_bit("issue", exp_issue, issue);
		compare_bit("kill", prev_flush, kill);
		compare_bit("wb_valid", exp_wb, wb_valid);
		if (exp_wb)
			compare_reg("wb_rd", exp_rd, wb_rd);
		for (int r = 0; r < NUM_REGS; r++)
			if (cnt[r] > 0)
				cnt[r]--;
		if (exp_issue && wr)
			cnt[rd] = (cls == FU_LOAD) ? LAT_LOAD : LAT_ALU;
		prev_flush = flush;
		if (wb_valid === 1'b1)
			wb_count++;
		issued = (issue === 1'b1);
	endtask

	// hold one instruction until it issues
	task automatic send(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2, output int stalls);
		logic issued;
		stalls = 0;
		issued = 1'b0;
		while (!issued)
		begin
			step(op, rd, rs1, rs2, 1'b1, 1'b0, 1'b0, issued);
			if (!issued)
				stalls++;
		end
	endtask

	task automatic idle();
		logic issued;
		step(OPC_OP, '0, '0, '0, 1'b0, 1'b0, 1'b0, issued);
	endtask

	task automatic drain();
		int busy;
		busy = 1;
		while (busy != 0)
		begin
			busy = 0;
			for (int r = 0; r < NUM_REGS; r++)
				busy += (cnt[r] != 0) ? 1 : 0;
			idle();
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("test %s finished with %0d failed checks", name, fail_count - fails_before);
	endtask

	task automatic test_alu_stream();
		int fails;
		int stalls;
		fails = fail_count;
		for (int i = 0; i < 8; i++)
		begin
			send(OPC_OP, reg_idx_t'(i + 1), reg_idx_t'(i + 10), reg_idx_t'(i + 20), stalls);
			check_count("stall cycles of an independent alu op", 0, stalls);
		end
		drain();
		report_test("alu_stream", fails);
	endtask

	task automatic test_load_use();
		int fails;
		int stalls;
		fails = fail_count;
		send(OPC_LOAD, 5'd5, 5'd1, 5'd0, stalls);
		send(OPC_OP, 5'd6, 5'd5, 5'd2, stalls);	// raw on x5
		check_count("stall cycles of a load-use op", LAT_LOAD - 1, stalls);
		drain();
		send(OPC_LOAD, 5'd7, 5'd1, 5'd0, stalls);
		send(OPC_OP_IMM, 5'd7, 5'd3, 5'd0, stalls);	// waw on x7
		check_count("stall cycles of a waw op", LAT_LOAD - 1, stalls);
		drain();
		report_test("load_use", fails);
	endtask

	task automatic test_x0_dest();
		int fails;
		int stalls;
		int wb_start;
		fails    = fail_count;
		wb_start = wb_count;
		send(OPC_OP_IMM, 5'd0, 5'd1, 5'd0, stalls);
		send(OPC_BRANCH, 5'd0, 5'd0, 5'd0, stalls);
		check_count("stall cycles of a branch after an x0 write", 0, stalls);
		send(OPC_STORE, 5'd0, 5'd0, 5'd0, stalls);
		check_count("stall cycles of a store after an x0 write", 0, stalls);
		repeat (LAT_LOAD + 1) idle();
		check_count("write-backs after x0 writes", 0, wb_count - wb_start);
		report_test("x0_dest", fails);
	endtask

	task automatic test_port_conflict();
		int fails;
		int stalls;
		fails = fail_count;
		if (LAT_LOAD > LAT_ALU)
		begin
			send(OPC_LOAD, 5'd8, 5'd1, 5'd0, stalls);
			repeat (LAT_LOAD - LAT_ALU - 1) idle();
			send(OPC_OP_IMM, 5'd9, 5'd2, 5'd0, stalls);
			check_count("stall cycles of an alu op on a taken result slot", 1, stalls);
			drain();
		end
		report_test("port_conflict", fails);
	endtask

	task automatic test_flush();
		int   fails;
		int   stalls;
		int   wb_start;
		logic issued;
		fails = fail_count;
		send(OPC_LOAD, 5'd10, 5'd1, 5'd0, stalls);
		wb_start = wb_count;
		step(OPC_OP, 5'd11, 5'd2, 5'd3, 1'b1, 1'b1, 1'b0, issued);	// taken branch
		idle();
		step(OPC_OP_IMM, 5'd12, 5'd4, 5'd0, 1'b1, 1'b0, 1'b1, issued);	// exception
		idle();
		drain();
		check_count("in-flight write-backs across a flush", 1, wb_count - wb_start);
		report_test("flush", fails);
	endtask

	task automatic test_random_mix();
		opcode_t ops [10];
		int      fails;
		int      stalls;
		int      sel;
		fails = fail_count;
		ops   = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OP_IMM, OPC_OP, OPC_BRANCH,
		          OPC_LOAD, OPC_STORE, 7'b1110011};	// last is a system op
		for (int i = 0; i < 40; i++)
		begin
			sel = int'($unsigned($random(seed)) % 10);
			send(ops[sel], reg_idx_t'($unsigned($random(seed)) % 8),
				reg_idx_t'($unsigned($random(seed)) % 8),
				reg_idx_t'($unsigned($random(seed)) % 8), stalls);
		end
		drain();
		report_test("random_mix", fails);
	endtask

	initial
	begin
		nrst        = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		btaken      = 1'b0;
		exception   = 1'b0;
		prev_flush  = 1'b0;
		wb_count    = 0;
		pass_count  = 0;
		fail_count  = 0;
		cycles      = 0;
		seed        = 32'h311b;
		for (int r = 0; r < NUM_REGS; r++)
			cnt[r] = 0;
		repeat (3) @(posedge clk);
		nrst <= 1'b1;
		idle();	// all outputs low out of reset
		test_alu_stream();
		test_load_use();
		test_x0_dest();
		test_port_conflict();
		test_flush();
		test_random_mix();
		$display("checks passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/issue_hazard_top.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_hazard_top
	import hazard_pkg::*;
#(
	parameter int LAT_ALU  = 1,
	parameter int LAT_LOAD = 3
)(
	input  logic        clk,
	input  logic        nrst,
	input  logic [31:0] instr,
	input  logic        instr_valid,
	input  logic        btaken,
	input  logic        exception,
	output logic        stall,
	output logic        issue,
	output logic        kill,
	output logic        wb_valid,
	output reg_idx_t    wb_rd
);

	fu_class_t fu_class;
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	reg_idx_t  rd;
	logic      uses_rs1;
	logic      uses_rs2;
	logic      writes_rd;
	logic      push;	// issued writer
	reg_idx_t  push_rd;
	logic      push_is_load;
	logic      alu_slot_busy;

	instr_decode u_decode (
		.instr     (instr),
		.fu_class  (fu_class),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.uses_rs1  (uses_rs1),
		.uses_rs2  (uses_rs2),
		.writes_rd (writes_rd)
	);

	reg_scoreboard u_scoreboard (
		.clk           (clk),
		.nrst          (nrst),
		.instr_valid   (instr_valid),
		.btaken        (btaken),
		.exception     (exception),
		.fu_class      (fu_class),
		.rs1           (rs1),
		.rs2           (rs2),
		.rd            (rd),
		.uses_rs1      (uses_rs1),
		.uses_rs2      (uses_rs2),
		.writes_rd     (writes_rd),
		.alu_slot_busy (alu_slot_busy),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.stall         (stall),
		.issue         (issue),
		.kill          (kill),
		.push          (push),
		.push_rd       (push_rd),
		.push_is_load  (push_is_load)
	);

	wb_pipeline #(
		.LAT_ALU  (LAT_ALU),
		.LAT_LOAD (LAT_LOAD)
	) u_wb_pipe (
		.clk           (clk),
		.nrst          (nrst),
		.push          (push),
		.push_rd       (push_rd),
		.push_is_load  (push_is_load),
		.alu_slot_busy (alu_slot_busy),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd)
	);

endmodule

`default_nettype wire

/* rtl/wb_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_pipeline
	import hazard_pkg::*;
#(
	parameter int LAT_ALU  = 1,
	parameter int LAT_LOAD = 3
)(
	input  logic     clk,
	input  logic     nrst,
	input  logic     push,
	input  reg_idx_t push_rd,
	input  logic     push_is_load,
	output logic     alu_slot_busy,
	output logic     wb_valid,
	output reg_idx_t wb_rd
);

	localparam int IDX_W = $clog2(LAT_LOAD);

	logic [LAT_LOAD-1:0] stg_valid;	// stage 0 drives write-back
	reg_idx_t            stg_rd [LAT_LOAD];
	logic [LAT_LOAD:0]   feed_valid;	// top bit is the empty shift-in
	logic [IDX_W-1:0]    push_stage;

	assign feed_valid = {1'b0, stg_valid};

	// entry stage sets the cycle count to write-back
	assign push_stage = push_is_load ? IDX_W'(LAT_LOAD - 1) : IDX_W'(LAT_ALU - 1);

	// older entry about to shift into the alu entry stage
	assign alu_slot_busy = feed_valid[LAT_ALU];

	always_ff @(posedge clk)
	begin
		if (!nrst)
			stg_valid <= '0;
		else
		begin
			stg_valid <= feed_valid[LAT_LOAD:1];
			if (push)
				stg_valid[push_stage] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < LAT_LOAD - 1; i++)
			stg_rd[i] <= stg_rd[i+1];
		if (push)
			stg_rd[push_stage] <= push_rd;
	end

	assign wb_valid = stg_valid[0];
	assign wb_rd    = stg_rd[0];

	// the scoreboard must hold an alu push whose stage is taken
	a_push_free : assert property (
		@(posedge clk) disable iff (!nrst)
		push |-> !feed_valid[int'(push_stage) + 1]
	) else $error("push of x%0d lands on an occupied stage", push_rd);

endmodule

`default_nettype wire

/* rtl/reg_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_scoreboard
	import hazard_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  logic      instr_valid,
	input  logic      btaken,
	input  logic      exception,
	input  fu_class_t fu_class,
	input  reg_idx_t  rs1,
	input  reg_idx_t  rs2,
	input  reg_idx_t  rd,
	input  logic      uses_rs1,
	input  logic      uses_rs2,
	input  logic      writes_rd,
	input  logic      alu_slot_busy,
	input  logic      wb_valid,
	input  reg_idx_t  wb_rd,
	output logic      stall,
	output logic      issue,
	output logic      kill,
	output logic      push,
	output reg_idx_t  push_rd,
	output logic      push_is_load
);

	logic [NUM_REGS-1:0] pending;	// one bit per architectural register
	logic [NUM_REGS-1:0] wb_clr;
	logic [NUM_REGS-1:0] pend_eff;
	logic [NUM_REGS-1:0] push_set;
	logic                flush;
	logic                reg_hazard;
	logic                port_hazard;
	logic                hazard;

	assign flush = btaken | exception;

	// a register written back this cycle already counts as ready
	assign wb_clr   = wb_valid ? (NUM_REGS'(1) << wb_rd) : '0;
	assign pend_eff = pending & ~wb_clr;

	// raw on either source, waw on the destination
	assign reg_hazard = (uses_rs1  && pend_eff[rs1]) ||
	                    (uses_rs2  && pend_eff[rs2]) ||
	                    (writes_rd && pend_eff[rd]);

	// alu result would collide with an older load on the write-back port
	assign port_hazard = (fu_class == FU_ALU) && writes_rd && alu_slot_busy;

	assign hazard = reg_hazard || port_hazard;

	assign stall = instr_valid && !flush && hazard;
	assign issue = instr_valid && !flush && !hazard;

	assign push         = issue && writes_rd;
	assign push_rd      = rd;
	assign push_is_load = (fu_class == FU_LOAD);

	assign push_set = push ? (NUM_REGS'(1) << rd) : '0;

	// set wins over clear when a new writer reuses the retiring rd
	always_ff @(posedge clk)
	begin
		if (!nrst)
			pending <= '0;
		else
			pending <= pend_eff | push_set;
	end

	always_ff @(posedge clk)
	begin
		if (!nrst)
			kill <= 1'b0;
		else
			kill <= flush;	// one cycle after the flushed slot
	end

	// every completing result must belong to an issued writer
	a_wb_pending : assert property (
		@(posedge clk) disable iff (!nrst)
		wb_valid |-> pending[wb_rd]
	) else $error("write-back of x%0d which is not pending", wb_rd);

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode
	import hazard_pkg::*;
(
	input  logic      [31:0] instr,
	output fu_class_t        fu_class,
	output reg_idx_t         rs1,
	output reg_idx_t         rs2,
	output reg_idx_t         rd,
	output logic             uses_rs1,
	output logic             uses_rs2,
	output logic             writes_rd
);

	opcode_t opcode;

	assign opcode = instr[6:0];

	// register fields sit at the same bits in every format
	assign rd  = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	always_comb
	begin
		fu_class = FU_NONE;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		unique case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL:
				fu_class = FU_ALU;	// no source register
			OPC_JALR, OPC_OP_IMM:
			begin
				fu_class = FU_ALU;
				uses_rs1 = 1'b1;
			end
			OPC_OP:
			begin
				fu_class = FU_ALU;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OPC_BRANCH:
			begin
				fu_class = FU_BRANCH;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OPC_LOAD:
			begin
				fu_class = FU_LOAD;
				uses_rs1 = 1'b1;	// base address
			end
			OPC_STORE:
			begin
				fu_class = FU_STORE;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;	// store data
			end
			default:
				fu_class = FU_NONE;	// csr, fence, system
		endcase
	end

	// only alu and load results go to write-back, x0 is never written
	assign writes_rd = ((fu_class == FU_ALU) || (fu_class == FU_LOAD)) && (rd != '0);

endmodule

`default_nettype wire

/* rtl/hazard_pkg.sv */
`default_nettype none

package hazard_pkg;

	localparam int NUM_REGS  = 32;
	localparam int REG_IDX_W = $clog2(NUM_REGS);

	typedef logic [REG_IDX_W-1:0] reg_idx_t;	// x0..x31
	typedef logic [6:0]           opcode_t;		// instr[6:0]

	// RV32I major opcodes handled by the issue stage
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP     = 7'b0110011;

	typedef enum logic [2:0]
	{
		FU_NONE   = 3'd0,	// unsupported, issues without effect
		FU_ALU    = 3'd1,	// lui auipc jal jalr op-imm op
		FU_BRANCH = 3'd2,
		FU_LOAD   = 3'd3,
		FU_STORE  = 3'd4
	} fu_class_t;

endpackage

`default_nettype wire
